// ==== hdl/riscv_pkg.sv ====
package riscv_pkg;

	localparam int XLEN = 32;		// Integer register width
	localparam int REG_ADDR_W = 5;	// x0..x31

	// Major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// Conditional branch kinds, inst[14:12]
	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} branch_f3_e;

	// ALU funct3 for OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;	// SUB only on OP with inst[30]
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;	// inst[30] picks arithmetic
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;	// addi x0, x0, 0

endpackage

// ==== hdl/core_pkg.sv ====
package core_pkg;

	localparam int PC_W = 12;			// 4 KiB instruction space
	localparam int DMEM_ADDR_W = 11;	// Word address into data memory
	localparam int DMEM_WORDS = 2048;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	// Write-back source
	typedef enum logic [1:0] {WB_PC4, WB_ALU, WB_IMM, WB_LOAD} wb_sel_e;

	// Same code as the load/store funct3
	typedef enum logic [2:0] {
		MEM_B  = 3'b000,
		MEM_H  = 3'b001,
		MEM_W  = 3'b010,
		MEM_BU = 3'b100,
		MEM_HU = 3'b101
	} mem_size_e;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

	// Where an ID operand comes from
	typedef enum logic [1:0] {FWD_NONE, FWD_EXE, FWD_MEM, FWD_WB} fwd_src_e;

endpackage

// ==== hdl/fetch_stage.sv ====
module fetch_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic stall_if_id,
	input  logic flush_if_id,
	input  logic jump_taken,
	input  logic [core_pkg::PC_W-1:0] jump_target,
	input  logic branch_taken,
	input  logic [core_pkg::PC_W-1:0] branch_target,
	input  logic [riscv_pkg::XLEN-1:0] imem_inst,
	output logic [core_pkg::PC_W-1:0] imem_addr,
	output logic [core_pkg::PC_W-1:0] id_pc,
	output logic [core_pkg::PC_W-1:0] id_pc4,
	output logic [riscv_pkg::XLEN-1:0] id_inst
);
	import riscv_pkg::*;
	import core_pkg::*;

	logic [PC_W-1:0] pc;
	logic [PC_W-1:0] pc4;
	logic [PC_W-1:0] pc_next;

	assign imem_addr = pc;			// ROM answers in the same cycle
	assign pc4 = pc + PC_W'(4);

	// Branch from EXE is older, so it beats a jump from ID
	always_comb begin
		if (branch_taken) pc_next = branch_target;
		else if (stall_if_id) pc_next = pc;		// Jump waits out the load-use stall
		else if (jump_taken) pc_next = jump_target;
		else pc_next = pc4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) pc <= '0;
		else pc <= pc_next;
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (!rst_n || flush_if_id) begin
			id_inst <= NOP_INST;	// Squashed slot
		end else if (!stall_if_id) begin
			id_inst <= imem_inst;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_if_id) begin
			id_pc <= pc;
			id_pc4 <= pc4;
		end
	end

endmodule

// ==== hdl/decode_stage.sv ====
module decode_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic bubble_id_exe,
	input  logic flush_id_exe,
	input  logic [core_pkg::PC_W-1:0] id_pc,
	input  logic [core_pkg::PC_W-1:0] id_pc4,
	input  logic [riscv_pkg::XLEN-1:0] id_inst,
	input  logic [riscv_pkg::XLEN-1:0] rf_a,
	input  logic [riscv_pkg::XLEN-1:0] rf_b,
	input  core_pkg::fwd_src_e fwd_a,
	input  core_pkg::fwd_src_e fwd_b,
	input  logic [riscv_pkg::XLEN-1:0] exe_fwd_data,
	input  logic [riscv_pkg::XLEN-1:0] mem_fwd_data,
	input  logic [riscv_pkg::XLEN-1:0] wb_data,
	output logic [riscv_pkg::REG_ADDR_W-1:0] rs_a,
	output logic [riscv_pkg::REG_ADDR_W-1:0] rs_b,
	output logic uses_a,
	output logic uses_b,
	output logic jump_taken,
	output logic [core_pkg::PC_W-1:0] jump_target,
	output logic [riscv_pkg::XLEN-1:0] op_a,
	output logic [riscv_pkg::XLEN-1:0] op_b,
	output logic [riscv_pkg::XLEN-1:0] store_data,
	output logic [riscv_pkg::XLEN-1:0] exe_imm,
	output logic [riscv_pkg::REG_ADDR_W-1:0] exe_rd,
	output logic exe_we,
	output core_pkg::alu_op_e exe_alu_op,
	output core_pkg::wb_sel_e exe_wb_sel,
	output core_pkg::mem_size_e exe_mem_size,
	output logic exe_is_store,
	output logic exe_is_branch,
	output riscv_pkg::branch_f3_e exe_branch_f3,
	output logic [core_pkg::PC_W-1:0] exe_branch_target,
	output logic [core_pkg::PC_W-1:0] exe_pc4
);
	import riscv_pkg::*;
	import core_pkg::*;

	opcode_e opcode;
	logic [2:0] f3;
	alu_op_e alu_op;
	wb_sel_e wb_sel;
	imm_sel_e imm_sel;
	logic we;
	logic is_store;
	logic is_branch;
	logic is_jalr;
	logic a_is_pc;
	logic b_is_imm;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] reg_a;			// Register values after forwarding
	logic [XLEN-1:0] reg_b;
	logic [XLEN-1:0] jalr_sum;
	logic [PC_W-1:0] pc_rel;		// JAL and branch target

	function automatic alu_op_e alu_decode(input logic [2:0] fn3, input logic alt);
		case (fn3)
			F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     return ALU_SLL;
			F3_SLT:     return ALU_SLT;
			F3_SLTU:    return ALU_SLTU;
			F3_XOR:     return ALU_XOR;
			F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
			F3_OR:      return ALU_OR;
			F3_AND:     return ALU_AND;
			default:    return ALU_ADD;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] fwd_pick(input fwd_src_e src, input logic [XLEN-1:0] rf);
		case (src)
			FWD_EXE: return exe_fwd_data;
			FWD_MEM: return mem_fwd_data;
			FWD_WB:  return wb_data;
			default: return rf;
		endcase
	endfunction

	assign opcode = opcode_e'(id_inst[6:0]);
	assign f3 = id_inst[14:12];
	assign rs_a = id_inst[19:15];
	assign rs_b = id_inst[24:20];

	assign we = opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP};
	assign uses_a = opcode inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
	assign uses_b = opcode inside {OPC_BRANCH, OPC_STORE, OPC_OP};
	assign b_is_imm = opcode inside {OPC_AUIPC, OPC_LOAD, OPC_STORE, OPC_OP_IMM};
	assign a_is_pc = (opcode == OPC_AUIPC);
	assign is_store = (opcode == OPC_STORE);
	assign is_branch = (opcode == OPC_BRANCH);
	assign is_jalr = (opcode == OPC_JALR);

	// Shift-immediates reuse inst[30] for SRAI only
	assign alu_op = (opcode == OPC_OP) ? alu_decode(f3, id_inst[30]) :
		(opcode == OPC_OP_IMM) ? alu_decode(f3, id_inst[30] && f3 == F3_SRL_SRA) : ALU_ADD;

	always_comb begin
		wb_sel = WB_ALU;
		imm_sel = IMM_I;	// JALR, loads, OP-IMM
		case (opcode)
			OPC_LUI: begin
				wb_sel = WB_IMM;
				imm_sel = IMM_U;
			end
			OPC_AUIPC:  imm_sel = IMM_U;
			OPC_JAL: begin
				wb_sel = WB_PC4;
				imm_sel = IMM_J;
			end
			OPC_JALR:   wb_sel = WB_PC4;	// Link value
			OPC_BRANCH: imm_sel = IMM_B;
			OPC_LOAD:   wb_sel = WB_LOAD;
			OPC_STORE:  imm_sel = IMM_S;
			default: ;
		endcase
	end

	always_comb begin
		case (imm_sel)
			IMM_S:   imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
			IMM_B:   imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
				id_inst[11:8], 1'b0};
			IMM_U:   imm = {id_inst[31:12], 12'b0};
			IMM_J:   imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
				id_inst[30:21], 1'b0};
			default: imm = {{20{id_inst[31]}}, id_inst[31:20]};
		endcase
	end

	always_comb begin
		reg_a = fwd_pick(fwd_a, rf_a);
		reg_b = fwd_pick(fwd_b, rf_b);
	end

	// Jumps leave from ID
	assign pc_rel = id_pc + imm[PC_W-1:0];
	assign jalr_sum = reg_a + imm;
	assign jump_taken = (opcode == OPC_JAL) || is_jalr;
	assign jump_target = is_jalr ? {jalr_sum[PC_W-1:1], 1'b0} : pc_rel;

	// ID/EXE control, bubble and flush both leave a NOP
	always_ff @(posedge clk) begin
		if (!rst_n || bubble_id_exe || flush_id_exe) begin
			exe_rd <= '0;
			exe_we <= 1'b0;
			exe_is_store <= 1'b0;
			exe_is_branch <= 1'b0;
			exe_alu_op <= ALU_ADD;
			exe_wb_sel <= WB_ALU;
		end else begin
			exe_rd <= id_inst[11:7];
			exe_we <= we;
			exe_is_store <= is_store;
			exe_is_branch <= is_branch;
			exe_alu_op <= alu_op;
			exe_wb_sel <= wb_sel;
		end
	end

	// ID/EXE payload
	always_ff @(posedge clk) begin
		op_a <= a_is_pc ? XLEN'(id_pc) : reg_a;
		op_b <= b_is_imm ? imm : reg_b;
		store_data <= reg_b;
		exe_imm <= imm;
		exe_mem_size <= mem_size_e'(f3);
		exe_branch_f3 <= branch_f3_e'(f3);
		exe_branch_target <= pc_rel;
		exe_pc4 <= id_pc4;
	end

endmodule

// ==== hdl/regfile.sv ====
module regfile (
	input  logic clk,
	input  logic rst_n,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] rs_a,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] rs_b,
	input  logic wb_we,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd,
	input  logic [riscv_pkg::XLEN-1:0] wb_data,
	output logic [riscv_pkg::XLEN-1:0] rf_a,
	output logic [riscv_pkg::XLEN-1:0] rf_b
);
	import riscv_pkg::*;

	logic [XLEN-1:0] regs [2**REG_ADDR_W];	// regs[0] never written
	logic wr_live;

	assign wr_live = wb_we && (wb_rd != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) regs[i] <= '0;
		end else if (wr_live) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// Same-cycle write shows through on reads
	assign rf_a = (wr_live && wb_rd == rs_a) ? wb_data : regs[rs_a];
	assign rf_b = (wr_live && wb_rd == rs_b) ? wb_data : regs[rs_b];

endmodule

// ==== hdl/hazard_unit.sv ====
module hazard_unit (
	input  logic [riscv_pkg::REG_ADDR_W-1:0] rs_a,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] rs_b,
	input  logic uses_a,
	input  logic uses_b,
	input  logic jump_taken,
	input  logic branch_taken,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] exe_rd,
	input  logic exe_we,
	input  logic exe_is_load,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] mem_rd,
	input  logic mem_we,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd,
	input  logic wb_we,
	output core_pkg::fwd_src_e fwd_a,
	output core_pkg::fwd_src_e fwd_b,
	output logic stall_if_id,
	output logic bubble_id_exe,
	output logic flush_if_id,
	output logic flush_id_exe
);
	import riscv_pkg::*;
	import core_pkg::*;

	logic load_use;

	// Youngest writer wins, x0 is never forwarded
	function automatic fwd_src_e pick_src(input logic [REG_ADDR_W-1:0] rs, input logic used);
		if (!used || rs == '0) return FWD_NONE;
		if (exe_we && exe_rd == rs) return FWD_EXE;
		if (mem_we && mem_rd == rs) return FWD_MEM;
		if (wb_we && wb_rd == rs) return FWD_WB;
		return FWD_NONE;
	endfunction

	always_comb begin
		fwd_a = pick_src(rs_a, uses_a);
		fwd_b = pick_src(rs_b, uses_b);
	end

	// Load data only exists in MEM, so hold ID one cycle
	assign load_use = exe_is_load && exe_we && (exe_rd != '0) &&
		((uses_a && rs_a == exe_rd) || (uses_b && rs_b == exe_rd));

	assign stall_if_id = load_use;
	assign bubble_id_exe = load_use;	// NOP into EXE while ID holds
	assign flush_if_id = branch_taken || (jump_taken && !load_use);
	assign flush_id_exe = branch_taken;	// Two younger slots die on a taken branch

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic [riscv_pkg::XLEN-1:0] op_a,
	input  logic [riscv_pkg::XLEN-1:0] op_b,
	input  logic [riscv_pkg::XLEN-1:0] store_data,
	input  logic [riscv_pkg::XLEN-1:0] exe_imm,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] exe_rd,
	input  logic exe_we,
	input  core_pkg::alu_op_e exe_alu_op,
	input  core_pkg::wb_sel_e exe_wb_sel,
	input  core_pkg::mem_size_e exe_mem_size,
	input  logic exe_is_store,
	input  logic exe_is_branch,
	input  riscv_pkg::branch_f3_e exe_branch_f3,
	input  logic [core_pkg::PC_W-1:0] exe_branch_target,
	input  logic [core_pkg::PC_W-1:0] exe_pc4,
	output logic [riscv_pkg::XLEN-1:0] exe_fwd_data,
	output logic exe_is_load,
	output logic branch_taken,
	output logic [core_pkg::PC_W-1:0] branch_target,
	output logic [3:0] dm_be,
	output logic [riscv_pkg::XLEN-1:0] dm_wdata,
	output logic [core_pkg::DMEM_ADDR_W-1:0] dm_addr,
	output logic [riscv_pkg::REG_ADDR_W-1:0] mem_rd,
	output logic mem_we,
	output core_pkg::wb_sel_e mem_wb_sel,
	output core_pkg::mem_size_e mem_mem_size,
	output logic [riscv_pkg::XLEN-1:0] mem_alu,
	output logic [riscv_pkg::XLEN-1:0] mem_imm,
	output logic [core_pkg::PC_W-1:0] mem_pc4
);
	import riscv_pkg::*;
	import core_pkg::*;

	logic [XLEN-1:0] alu_res;
	logic eq;
	logic lt;
	logic ltu;
	logic cond;
	logic [3:0] be;

	// Compare flags straight off the operands
	assign eq = (op_a == op_b);
	assign lt = ($signed(op_a) < $signed(op_b));
	assign ltu = (op_a < op_b);

	always_comb begin
		case (exe_alu_op)
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << op_b[4:0];
			ALU_SLT:  alu_res = XLEN'(lt);
			ALU_SLTU: alu_res = XLEN'(ltu);
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> op_b[4:0];
			ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			default:  alu_res = op_a + op_b;	// Also address and AUIPC sums
		endcase
	end

	always_comb begin
		case (exe_branch_f3)
			F3_BEQ:  cond = eq;
			F3_BNE:  cond = !eq;
			F3_BLT:  cond = lt;
			F3_BGE:  cond = !lt;
			F3_BLTU: cond = ltu;
			F3_BGEU: cond = !ltu;
			default: cond = 1'b0;
		endcase
	end

	assign branch_taken = exe_is_branch && cond;	// Predicted not taken
	assign branch_target = exe_branch_target;		// Computed back in ID

	// Loads are not ready here, hazard unit stalls on them
	assign exe_is_load = (exe_wb_sel == WB_LOAD);
	assign exe_fwd_data = (exe_wb_sel == WB_PC4) ? XLEN'(exe_pc4) :
		(exe_wb_sel == WB_IMM) ? exe_imm : alu_res;

	// Store lane steering
	always_comb begin
		case (exe_mem_size)
			MEM_B: begin
				be = 4'b0001 << alu_res[1:0];
				dm_wdata = {4{store_data[7:0]}};
			end
			MEM_H: begin
				be = alu_res[1] ? 4'b1100 : 4'b0011;
				dm_wdata = {2{store_data[15:0]}};
			end
			default: begin
				be = 4'b1111;
				dm_wdata = store_data;
			end
		endcase
	end

	assign dm_be = exe_is_store ? be : 4'b0000;
	assign dm_addr = alu_res[DMEM_ADDR_W+1:2];	// Written at the edge that ends EXE

	// EXE/MEM register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_rd <= '0;
			mem_we <= 1'b0;
			mem_wb_sel <= WB_ALU;
			mem_mem_size <= MEM_W;
		end else begin
			mem_rd <= exe_rd;
			mem_we <= exe_we;
			mem_wb_sel <= exe_wb_sel;
			mem_mem_size <= exe_mem_size;
		end
	end

	always_ff @(posedge clk) begin
		mem_alu <= alu_res;
		mem_imm <= exe_imm;
		mem_pc4 <= exe_pc4;
	end

endmodule

// ==== hdl/memory_stage.sv ====
module memory_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic [3:0] dm_be,
	input  logic [riscv_pkg::XLEN-1:0] dm_wdata,
	input  logic [core_pkg::DMEM_ADDR_W-1:0] dm_addr,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] mem_rd,
	input  logic mem_we,
	input  core_pkg::wb_sel_e mem_wb_sel,
	input  core_pkg::mem_size_e mem_mem_size,
	input  logic [riscv_pkg::XLEN-1:0] mem_alu,
	input  logic [riscv_pkg::XLEN-1:0] mem_imm,
	input  logic [core_pkg::PC_W-1:0] mem_pc4,
	input  logic [3:0] con_write,
	input  logic [core_pkg::DMEM_ADDR_W-1:0] con_addr,
	input  logic [riscv_pkg::XLEN-1:0] con_in,
	output logic [riscv_pkg::XLEN-1:0] mem_fwd_data,
	output logic wb_we,
	output logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd,
	output logic [riscv_pkg::XLEN-1:0] wb_data,
	output logic [riscv_pkg::XLEN-1:0] con_out
);
	import riscv_pkg::*;
	import core_pkg::*;

	logic [XLEN-1:0] dmem [DMEM_WORDS];
	logic [XLEN-1:0] rdata;
	logic [XLEN-1:0] load_data;
	logic [7:0] ld_byte;
	logic [15:0] ld_half;
	logic con_overlap;

	// Controller owns the word when both ports hit it
	assign con_overlap = (con_write != 4'b0000) && (con_addr == dm_addr);

	always_ff @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (dm_be[b] && !con_overlap) dmem[dm_addr][8*b +: 8] <= dm_wdata[8*b +: 8];
			if (con_write[b]) dmem[con_addr][8*b +: 8] <= con_in[8*b +: 8];
		end
		con_out <= dmem[con_addr];	// One cycle behind con_addr
	end

	assign rdata = dmem[mem_alu[DMEM_ADDR_W+1:2]];	// Async read at the MEM address

	// Load lane pick and extension
	always_comb begin
		ld_byte = rdata[8*mem_alu[1:0] +: 8];
		ld_half = mem_alu[1] ? rdata[31:16] : rdata[15:0];
		case (mem_mem_size)
			MEM_B:   load_data = {{24{ld_byte[7]}}, ld_byte};
			MEM_BU:  load_data = {24'b0, ld_byte};
			MEM_H:   load_data = {{16{ld_half[15]}}, ld_half};
			MEM_HU:  load_data = {16'b0, ld_half};
			default: load_data = rdata;
		endcase
	end

	// Write-back select, also the MEM forward value
	always_comb begin
		case (mem_wb_sel)
			WB_PC4:  mem_fwd_data = XLEN'(mem_pc4);
			WB_IMM:  mem_fwd_data = mem_imm;
			WB_LOAD: mem_fwd_data = load_data;
			default: mem_fwd_data = mem_alu;
		endcase
	end

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_we <= 1'b0;
			wb_rd <= '0;
		end else begin
			wb_we <= mem_we;
			wb_rd <= mem_rd;
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= mem_fwd_data;
	end

endmodule

// ==== hdl/core.sv ====
module core (
	input  logic clk,
	input  logic rst_n,
	input  logic [riscv_pkg::XLEN-1:0] imem_inst,
	input  logic [3:0] con_write,
	input  logic [core_pkg::DMEM_ADDR_W-1:0] con_addr,		// Word address
	input  logic [riscv_pkg::XLEN-1:0] con_in,
	output logic [core_pkg::PC_W-1:0] imem_addr,
	output logic [riscv_pkg::XLEN-1:0] con_out
);
	import riscv_pkg::*;
	import core_pkg::*;

	// Hazard control
	logic stall_if_id;
	logic bubble_id_exe;
	logic flush_if_id;
	logic flush_id_exe;
	fwd_src_e fwd_a;
	fwd_src_e fwd_b;

	// Redirects
	logic jump_taken;
	logic [PC_W-1:0] jump_target;
	logic branch_taken;
	logic [PC_W-1:0] branch_target;

	// ID side
	logic [PC_W-1:0] id_pc;
	logic [PC_W-1:0] id_pc4;
	logic [XLEN-1:0] id_inst;
	logic [REG_ADDR_W-1:0] rs_a;
	logic [REG_ADDR_W-1:0] rs_b;
	logic uses_a;
	logic uses_b;
	logic [XLEN-1:0] rf_a;
	logic [XLEN-1:0] rf_b;

	// ID/EXE outputs
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] store_data;
	logic [XLEN-1:0] exe_imm;
	logic [REG_ADDR_W-1:0] exe_rd;
	logic exe_we;
	alu_op_e exe_alu_op;
	wb_sel_e exe_wb_sel;
	mem_size_e exe_mem_size;
	logic exe_is_store;
	logic exe_is_branch;
	branch_f3_e exe_branch_f3;
	logic [PC_W-1:0] exe_branch_target;
	logic [PC_W-1:0] exe_pc4;

	// EXE side and EXE/MEM
	logic [XLEN-1:0] exe_fwd_data;
	logic exe_is_load;
	logic [3:0] dm_be;
	logic [XLEN-1:0] dm_wdata;
	logic [DMEM_ADDR_W-1:0] dm_addr;
	logic [REG_ADDR_W-1:0] mem_rd;
	logic mem_we;
	wb_sel_e mem_wb_sel;
	mem_size_e mem_mem_size;
	logic [XLEN-1:0] mem_alu;
	logic [XLEN-1:0] mem_imm;
	logic [PC_W-1:0] mem_pc4;

	// MEM forward and WB
	logic [XLEN-1:0] mem_fwd_data;
	logic wb_we;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [XLEN-1:0] wb_data;

	// Every port shares its name with the net above
	fetch_stage FETCH (.*);
	decode_stage DECODE (.*);
	regfile RF (.*);
	hazard_unit HAZARD (.*);
	execute_stage EXECUTE (.*);
	memory_stage MEMORY (.*);

endmodule

// ==== tb/core_properties.sv ====
module core_properties (
	input  logic clk,
	input  logic rst_n,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] rs_a,
	input  logic [riscv_pkg::REG_ADDR_W-1:0] rs_b,
	input  core_pkg::fwd_src_e fwd_a,
	input  core_pkg::fwd_src_e fwd_b,
	input  logic stall_if_id,
	input  logic bubble_id_exe,
	input  logic flush_if_id,
	input  logic flush_id_exe
);
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	// Hazard controls resolve every cycle once out of reset
	ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({stall_if_id, bubble_id_exe, flush_if_id, flush_id_exe}))
		else $error("hazard control signal is unknown");

	// Bubble in EXE ends the load-use condition
	stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		stall_if_id |=> !stall_if_id)
		else $error("load-use stall held for more than one cycle");

	no_fwd_x0_a: assert property (@(posedge clk) disable iff (!rst_n)
		(rs_a == '0) |-> (fwd_a == FWD_NONE))
		else $error("operand A forwarded from x0");

	no_fwd_x0_b: assert property (@(posedge clk) disable iff (!rst_n)
		(rs_b == '0) |-> (fwd_b == FWD_NONE))
		else $error("operand B forwarded from x0");

endmodule

// ==== tb/tb_core.sv ====
module tb_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_RECS = 256;
	localparam int ROM_WORDS = 1024;	// Covers the 12-bit PC space
	localparam int MARGIN = 200;		// Cycles on top of the budgets

	// Record kinds in the test data
	localparam logic [7:0] REC_PROG = 8'h01;
	localparam logic [7:0] REC_INIT = 8'h02;
	localparam logic [7:0] REC_EXP = 8'h03;
	localparam logic [7:0] REC_END = 8'h04;
	localparam logic [7:0] REC_STOP = 8'hFF;

	logic clk;
	logic rst_n;
	logic [31:0] imem_inst;
	logic [3:0] con_write;
	logic [10:0] con_addr;
	logic [31:0] con_in;
	logic [11:0] imem_addr;
	logic [31:0] con_out;

	logic [63:0] recs [MAX_RECS];	// kind | word addr | data
	logic [31:0] rom [ROM_WORDS];
	int cycles = 0;
	int limit = 0;					// Watchdog idle until set
	int num_tests = 0;
	int pass_count = 0;
	int fail_count = 0;
	logic bad_data = 1'b0;

	core UUT (
		.clk(clk),
		.rst_n(rst_n),
		.imem_inst(imem_inst),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.imem_addr(imem_addr),
		.con_out(con_out)
	);

	bind hazard_unit core_properties PROPS (
		.clk(tb_core.clk),
		.rst_n(tb_core.rst_n),
		.rs_a(rs_a),
		.rs_b(rs_b),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.stall_if_id(stall_if_id),
		.bubble_id_exe(bubble_id_exe),
		.flush_if_id(flush_if_id),
		.flush_id_exe(flush_id_exe)
	);

	assign imem_inst = rom[imem_addr[11:2]];	// Combinational ROM read by word

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic rec_valid(input int idx);
		if (idx >= MAX_RECS) return 1'b0;
		if ($isunknown(recs[idx][63:56])) return 1'b0;
		return recs[idx][63:56] != REC_STOP;
	endfunction

	initial begin
		int ptr;
		int slot;
		int held;
		int budget;
		int errs;
		int total;
		logic [7:0] kind;
		logic [31:0] want;
		logic [11:0] loop_pc;
		logic [10:0] exp_addr [$];
		logic [31:0] exp_data [$];
		logic [10:0] init_addr [$];
		logic [31:0] init_data [$];

		rst_n = 1'b0;
		con_write = 4'b0000;
		con_addr = '0;
		con_in = '0;
		$readmemh("tb/core_testdata.txt", recs);

		// Budgets plus reset, preload and readback cycles
		total = 0;
		ptr = 0;
		while (rec_valid(ptr)) begin
			if (recs[ptr][63:56] == REC_END) total += 6 + int'(recs[ptr][31:0]);
			total += 2;
			ptr++;
		end
		limit = total + MARGIN;

		ptr = 0;
		while (rec_valid(ptr) && !bad_data) begin
			@(negedge clk);
			rst_n = 1'b0;					// Core idles while the test loads
			slot = 0;
			budget = 0;
			while (budget == 0) begin
				kind = rec_valid(ptr) ? recs[ptr][63:56] : REC_STOP;
				case (kind)
					REC_PROG: begin
						rom[slot] = recs[ptr][31:0];
						slot++;
					end
					REC_INIT: begin
						init_addr.push_back(recs[ptr][42:32]);
						init_data.push_back(recs[ptr][31:0]);
					end
					REC_EXP: begin
						exp_addr.push_back(recs[ptr][42:32]);
						exp_data.push_back(recs[ptr][31:0]);
					end
					REC_END: budget = int'(recs[ptr][31:0]);
					default: begin
						bad_data = 1'b1;	// Missing end record or unknown kind
						budget = -1;
					end
				endcase
				ptr++;
			end
			if (!bad_data) begin
				// Preload through the con port while reset holds for 3 cycles or more
				held = 0;
				while (held < 3 || init_addr.size() > 0) begin
					if (init_addr.size() > 0) begin
						con_write = 4'b1111;
						con_addr = init_addr.pop_front();
						con_in = init_data.pop_front();
					end else begin
						con_write = 4'b0000;
					end
					@(negedge clk);
					held++;
				end
				con_write = 4'b0000;
				rst_n = 1'b1;
				repeat (budget) @(negedge clk);

				errs = 0;

				// Closing self-loop keeps the PC on the jump or the word after it
				loop_pc = 12'((slot - 1) * 4);
				if (imem_addr !== loop_pc && imem_addr !== loop_pc + 12'd4) begin
					$display("[FAIL] imem_addr: expected %03h or %03h, got %03h",
						loop_pc, loop_pc + 12'd4, imem_addr);
					errs++;
				end

				while (exp_addr.size() > 0) begin
					con_addr = exp_addr.pop_front();
					want = exp_data.pop_front();
					@(negedge clk);		// con_out registered at the edge between
					if (con_out !== want) begin
						$display("[FAIL] con_out word %03h: expected %08h, got %08h",
							con_addr, want, con_out);
						errs++;
					end
				end
				num_tests++;
				if (errs == 0) begin
					pass_count++;
					$display("test %0d ok", num_tests);
				end else begin
					fail_count++;
					$display("test %0d: %0d wrong values", num_tests, errs);
				end
			end
		end

		if (bad_data) $display("Malformed record %0d in the test data", ptr - 1);
		$display("%0d tests run, %0d passed, %0d failed", num_tests, pass_count, fail_count);
		if (fail_count == 0 && !bad_data && num_tests > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== tb/core_testdata.txt ====
// kind_addr_data: 01 program word, 02 preload word, 03 expected word, 04 end (budget)
// addr is a data word address, FF ends the file
// Test 1, dependent ALU chain
01_000000_00500093 // addi x1, x0, 5
01_000000_00708113 // addi x2, x1, 7
01_000000_001101B3 // add  x3, x2, x1
01_000000_40118233 // sub  x4, x3, x1
01_000000_00321293 // slli x5, x4, 3
01_000000_0032C333 // xor  x6, x5, x3
01_000000_10602023 // sw   x6, 0x100(x0)
01_000000_10402223 // sw   x4, 0x104(x0)
01_000000_0000006F // jal  x0, 0
03_000040_00000071
03_000041_0000000C
04_000000_00000028
// Test 2, sub-word loads and stores
02_000042_8081F2F3
02_000048_11223344
02_000049_55667788
01_000000_10900083 // lb   x1, 0x109(x0)
01_000000_10B04103 // lbu  x2, 0x10B(x0)
01_000000_10A01183 // lh   x3, 0x10A(x0)
01_000000_10805203 // lhu  x4, 0x108(x0)
01_000000_10102823 // sw   x1, 0x110(x0)
01_000000_10202A23 // sw   x2, 0x114(x0)
01_000000_10302C23 // sw   x3, 0x118(x0)
01_000000_10402E23 // sw   x4, 0x11C(x0)
01_000000_122000A3 // sb   x2, 0x121(x0)
01_000000_12401323 // sh   x4, 0x126(x0)
01_000000_0000006F // jal  x0, 0
03_000044_FFFFFFF2
03_000045_00000080
03_000046_FFFF8081
03_000047_0000F2F3
03_000048_11228044
03_000049_F2F37788
04_000000_00000028
// Test 3, load followed by use
02_000050_00000029
01_000000_14002083 // lw   x1, 0x140(x0)
01_000000_00108113 // addi x2, x1, 1
01_000000_14002183 // lw   x3, 0x140(x0)
01_000000_00318233 // add  x4, x3, x3
01_000000_14002283 // lw   x5, 0x140(x0)
01_000000_14502623 // sw   x5, 0x14C(x0)
01_000000_14202223 // sw   x2, 0x144(x0)
01_000000_14402423 // sw   x4, 0x148(x0)
01_000000_0000006F // jal  x0, 0
03_000051_0000002A
03_000052_00000052
03_000053_00000029
04_000000_00000028
// Test 4, branches taken (shadow store) and not taken (adds a bit to x5)
02_000060_A5A5A5A5
01_000000_FFF00093 // addi x1, x0, -1
01_000000_00100113 // addi x2, x0, 1
01_000000_00210463 // beq  x2, x2, +8
01_000000_18002023 // sw   x0, 0x180(x0)
01_000000_00208463 // beq  x1, x2, +8
01_000000_00128293 // addi x5, x5, 1
01_000000_00209463 // bne  x1, x2, +8
01_000000_18002023 // sw   x0, 0x180(x0)
01_000000_00211463 // bne  x2, x2, +8
01_000000_00228293 // addi x5, x5, 2
01_000000_0020C463 // blt  x1, x2, +8
01_000000_18002023 // sw   x0, 0x180(x0)
01_000000_00114463 // blt  x2, x1, +8
01_000000_00428293 // addi x5, x5, 4
01_000000_00115463 // bge  x2, x1, +8
01_000000_18002023 // sw   x0, 0x180(x0)
01_000000_0020D463 // bge  x1, x2, +8
01_000000_00828293 // addi x5, x5, 8
01_000000_00116463 // bltu x2, x1, +8
01_000000_18002023 // sw   x0, 0x180(x0)
01_000000_0020E463 // bltu x1, x2, +8
01_000000_01028293 // addi x5, x5, 16
01_000000_0020F463 // bgeu x1, x2, +8
01_000000_18002023 // sw   x0, 0x180(x0)
01_000000_00117463 // bgeu x2, x1, +8
01_000000_02028293 // addi x5, x5, 32
01_000000_18502223 // sw   x5, 0x184(x0)
01_000000_0000006F // jal  x0, 0
03_000060_A5A5A5A5
03_000061_0000003F
04_000000_00000040
// Test 5, JAL and JALR links, x0 stays zero
02_000070_5A5A5A5A
02_000073_FFFFFFFF
01_000000_00500013 // addi x0, x0, 5
01_000000_00C000EF // jal  x1, +12
01_000000_1C002023 // sw   x0, 0x1C0(x0)
01_000000_1C002023 // sw   x0, 0x1C0(x0)
01_000000_01408167 // jalr x2, 20(x1)
01_000000_1C002023 // sw   x0, 0x1C0(x0)
01_000000_1C002023 // sw   x0, 0x1C0(x0)
01_000000_1C102223 // sw   x1, 0x1C4(x0)
01_000000_1C202423 // sw   x2, 0x1C8(x0)
01_000000_1C002623 // sw   x0, 0x1CC(x0)
01_000000_0000006F // jal  x0, 0
03_000070_5A5A5A5A
03_000071_00000008
03_000072_00000014
03_000073_00000000
04_000000_00000028
// Test 6, con port in and out
02_000080_12345678
01_000000_20002083 // lw   x1, 0x200(x0)
01_000000_11108113 // addi x2, x1, 0x111
01_000000_20202223 // sw   x2, 0x204(x0)
01_000000_0000006F // jal  x0, 0
03_000081_12345789
04_000000_00000028
FF_000000_00000000

// ==== sim.f ====
hdl/riscv_pkg.sv
hdl/core_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/regfile.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/core.sv
tb/core_properties.sv
tb/tb_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_core -Mdir obj_dir

# A failing simulation still leaves its log for the check below
./obj_dir/Vtb_core > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
	exit 0
fi
exit 1
